// ==== common/acc_disp_pkg.sv ====
// ======================================
// Accelerator dispatcher package
// Widths, depths, encodings and payloads
// ======================================

package acc_disp_pkg;

  // Datapath and scoreboard sizing
  localparam int unsigned XLEN             = 32;
  localparam int unsigned TRANS_ID_W       = 3;
  localparam int unsigned NR_SB_ENTRIES    = 2 ** TRANS_ID_W;
  localparam int unsigned FRM_W            = 3;

  // Instruction queue sizing
  localparam int unsigned INSN_QUEUE_DEPTH = 3;
  localparam int unsigned QUEUE_PTR_W      = $clog2(INSN_QUEUE_DEPTH);
  localparam int unsigned QUEUE_CNT_W      = $clog2(INSN_QUEUE_DEPTH + 1);

  // Width of each pending load/store counter
  localparam int unsigned PEND_CNT_W       = 3;

  // Functional unit of the instruction at the issue stage
  typedef enum logic [2:0] {
    FU_NONE  = 3'd0,
    FU_ALU   = 3'd1,
    FU_LOAD  = 3'd2,
    FU_STORE = 3'd3,
    FU_ACCEL = 3'd4
  } fu_e;

  // Memory class of an accelerator operation
  typedef enum logic [1:0] {
    ACC_OP_OTHER = 2'd0,
    ACC_OP_LOAD  = 2'd1,
    ACC_OP_STORE = 2'd2
  } acc_op_e;

  // Entry of the instruction queue
  typedef struct packed {
    logic [31:0]           insn;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [TRANS_ID_W-1:0] trans_id;
    acc_op_e               op;
  } acc_insn_t;

  // Request payload toward the accelerator
  typedef struct packed {
    logic [31:0]           insn;
    logic [XLEN-1:0]       rs1;
    logic [XLEN-1:0]       rs2;
    logic [FRM_W-1:0]      frm;
    logic [TRANS_ID_W-1:0] trans_id;
  } acc_req_t;

endpackage

// ==== hw/acc_dispatcher/acc_pending_counter.sv ====
// ======================================
// Pending operation counter
// Up/down count with synchronous clear
// ======================================

`timescale 1ns/1ps

module acc_pending_counter import acc_disp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  clear_i,
  input  logic                  inc_i,
  input  logic                  dec_i,
  output logic [PEND_CNT_W-1:0] count_o
);

  logic [PEND_CNT_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (clear_i) begin
      // Clear wins over a same-cycle event
      count_q <= '0;
    end else if (inc_i && !dec_i) begin
      count_q <= count_q + 1'b1;
    end else if (dec_i && !inc_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign count_o = count_q;

endmodule

// ==== hw/acc_dispatcher/acc_mem_tracker.sv ====
// ======================================
// Accelerator memory tracker
// Pending load/store counts, barrier halt
// ======================================

`timescale 1ns/1ps

module acc_mem_tracker import acc_disp_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic flush_i,
  input  logic issue_ld_i,
  input  logic issue_st_i,
  input  logic disp_ld_i,
  input  logic disp_st_i,
  input  logic load_complete_i,
  input  logic store_complete_i,
  input  logic store_pending_i,
  input  logic commit_st_barrier_i,
  output logic no_ld_pending_o,
  output logic no_st_pending_o,
  output logic ctrl_halt_o
);

  logic [PEND_CNT_W-1:0] spec_ld_cnt;
  logic [PEND_CNT_W-1:0] disp_ld_cnt;
  logic [PEND_CNT_W-1:0] spec_st_cnt;
  logic [PEND_CNT_W-1:0] disp_st_cnt;
  logic                  wait_st_q;

  // Speculative loads, lost on flush
  acc_pending_counter i_spec_ld_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .clear_i  (flush_i),
    .inc_i    (issue_ld_i),
    .dec_i    (disp_ld_i),
    .count_o  (spec_ld_cnt)
  );

  // Dispatched loads, gone only on completion
  acc_pending_counter i_disp_ld_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .clear_i  (1'b0),
    .inc_i    (disp_ld_i),
    .dec_i    (load_complete_i),
    .count_o  (disp_ld_cnt)
  );

  acc_pending_counter i_spec_st_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .clear_i  (flush_i),
    .inc_i    (issue_st_i),
    .dec_i    (disp_st_i),
    .count_o  (spec_st_cnt)
  );

  acc_pending_counter i_disp_st_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .clear_i  (1'b0),
    .inc_i    (disp_st_i),
    .dec_i    (store_complete_i),
    .count_o  (disp_st_cnt)
  );

  assign no_ld_pending_o = (spec_ld_cnt == '0) && (disp_ld_cnt == '0);
  assign no_st_pending_o = (spec_st_cnt == '0) && (disp_st_cnt == '0);

  // Barrier arms the wait, it lasts while the accelerator has stores
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_st_q <= 1'b0;
    end else begin
      wait_st_q <= (wait_st_q | commit_st_barrier_i) & store_pending_i;
    end
  end

  assign ctrl_halt_o = wait_st_q;

endmodule

// ==== hw/acc_dispatcher/acc_issue_ctrl.sv ====
// ======================================
// Accelerator issue control
// Handshake detection and issue stall
// ======================================

`timescale 1ns/1ps

module acc_issue_ctrl import acc_disp_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    issue_hs_i,
  input  logic    issue_done_i,
  input  fu_e     issue_fu_i,
  input  acc_op_e issue_op_i,
  input  logic    flush_unissued_i,
  input  logic    queue_ready_i,
  input  logic    no_ld_pending_i,
  input  logic    no_st_pending_i,
  input  logic    acc_cons_en_i,
  output logic    push_o,
  output logic    issue_ld_o,
  output logic    issue_st_o,
  output logic    issue_stall_o
);

  logic acc_hs;
  logic push_q;

  // Fresh accelerator instruction accepted by the issue stage
  assign acc_hs = issue_hs_i & (issue_fu_i == FU_ACCEL) & ~issue_done_i & ~flush_unissued_i;

  // Operands arrive one cycle later, so push is delayed to match
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      push_q <= 1'b0;
    end else begin
      push_q <= acc_hs;
    end
  end

  assign push_o = push_q;

  // Speculative load/store counters see the handshake directly
  assign issue_ld_o = acc_hs & (issue_op_i == ACC_OP_LOAD);
  assign issue_st_o = acc_hs & (issue_op_i == ACC_OP_STORE);

  always_comb begin
    unique case (issue_fu_i)
      // No room left in the instruction queue
      FU_ACCEL: issue_stall_o = ~queue_ready_i;
      // Scalar load behind an accelerator store
      FU_LOAD:  issue_stall_o = acc_cons_en_i & ~no_st_pending_i;
      // Scalar store behind any accelerator memory access
      FU_STORE: issue_stall_o = acc_cons_en_i & (~no_st_pending_i | ~no_ld_pending_i);
      default:  issue_stall_o = 1'b0;
    endcase
  end

endmodule

// ==== hw/acc_dispatcher/acc_insn_queue.sv ====
// ======================================
// Accelerator instruction queue
// Circular FIFO with usage and flush
// ======================================

`timescale 1ns/1ps

module acc_insn_queue import acc_disp_pkg::*; #(
  parameter type payload_t = acc_insn_t
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     ready_o
);

  localparam logic [QUEUE_PTR_W-1:0] LAST_PTR = QUEUE_PTR_W'(INSN_QUEUE_DEPTH - 1);

  payload_t               mem_q [INSN_QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [QUEUE_CNT_W-1:0] usage_q;
  logic                   full;
  logic                   do_push;
  logic                   do_pop;

  assign full    = (usage_q == QUEUE_CNT_W'(INSN_QUEUE_DEPTH));
  assign empty_o = (usage_q == '0);
  // Keep one slot spare for the instruction already in flight
  assign ready_o = (usage_q < QUEUE_CNT_W'(INSN_QUEUE_DEPTH - 1));

  // A full queue still takes a push when the head leaves
  assign do_pop  = pop_i & ~empty_o;
  assign do_push = push_i & (~full | do_pop);

  // Head is read straight from storage
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      // Usage only moves when exactly one side is active
      if (do_push && !do_pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (do_pop && !do_push) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== hw/acc_dispatcher/acc_spec_tracker.sv ====
// ======================================
// Speculation tracker
// Holds instructions until committed
// ======================================

`timescale 1ns/1ps

module acc_spec_tracker import acc_disp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  logic [TRANS_ID_W-1:0] push_trans_id_i,
  input  logic                  head_valid_i,
  input  logic [TRANS_ID_W-1:0] head_trans_id_i,
  input  acc_op_e               head_op_i,
  input  logic                  commit_acc_i,
  input  logic [TRANS_ID_W-1:0] commit_trans_id_i,
  input  logic                  req_ready_i,
  output logic                  disp_valid_o,
  output logic                  pop_o,
  output logic                  disp_ld_o,
  output logic                  disp_st_o
);

  logic [NR_SB_ENTRIES-1:0] pending_d, pending_q;
  logic [NR_SB_ENTRIES-1:0] ready_d, ready_q;
  logic                     commit_ok;
  logic                     head_commit;

  // Commit only counts for an ID the dispatcher already holds
  assign commit_ok   = commit_acc_i & pending_q[commit_trans_id_i];
  assign head_commit = commit_ok & (commit_trans_id_i == head_trans_id_i);

  // Head may leave once non-speculative, commit bypass saves a cycle
  assign disp_valid_o = head_valid_i & (ready_q[head_trans_id_i] | head_commit);
  assign pop_o        = disp_valid_o & req_ready_i;
  assign disp_ld_o    = pop_o & (head_op_i == ACC_OP_LOAD);
  assign disp_st_o    = pop_o & (head_op_i == ACC_OP_STORE);

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    // New instruction entered the queue
    if (push_i) begin
      pending_d[push_trans_id_i] = 1'b1;
    end
    // Flush drops every speculative entry
    if (flush_i) begin
      pending_d = '0;
    end
    // Reached the scoreboard head
    if (commit_ok) begin
      pending_d[commit_trans_id_i] = 1'b0;
      ready_d[commit_trans_id_i]   = 1'b1;
    end
    // Handed to the request register
    if (pop_o) begin
      ready_d[head_trans_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

endmodule

// ==== hw/acc_dispatcher/acc_req_reg.sv ====
// ======================================
// Accelerator request register
// One-entry fall-through valid/ready stage
// ======================================

`timescale 1ns/1ps

module acc_req_reg import acc_disp_pkg::*; #(
  parameter type payload_t = acc_req_t
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  logic     full_q;
  payload_t data_q;
  logic     capture;

  // Accept new data only while the slot is free
  assign ready_o = ~full_q;
  assign valid_o = full_q | valid_i;
  // Empty slot lets the input fall through
  assign data_o  = full_q ? data_q : data_i;

  // Park the request when downstream stalls it
  assign capture = valid_i & ~full_q & ~ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end else if (full_q && ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload held stable until accepted
  always_ff @(posedge clk_i) begin
    if (capture) begin
      data_q <= data_i;
    end
  end

endmodule

// ==== hw/acc_dispatcher/acc_disp_top.sv ====
// ======================================
// Accelerator dispatcher top level
// Queues issued instructions, sends them
// once non-speculative, returns results
// ======================================

`timescale 1ns/1ps

module acc_disp_top import acc_disp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Issue stage
  input  logic                  issue_hs_i,
  input  logic                  issue_done_i,
  input  fu_e                   issue_fu_i,
  input  acc_op_e               issue_op_i,
  input  logic                  flush_unissued_i,
  input  logic                  flush_ex_i,
  input  logic [31:0]           ex_insn_i,
  input  logic [XLEN-1:0]       ex_operand_a_i,
  input  logic [XLEN-1:0]       ex_operand_b_i,
  input  logic [TRANS_ID_W-1:0] ex_trans_id_i,
  input  acc_op_e               ex_op_i,
  input  logic [FRM_W-1:0]      fcsr_frm_i,
  input  logic                  acc_cons_en_i,
  output logic                  issue_stall_o,
  // Commit stage and controller
  input  logic                  commit_acc_i,
  input  logic [TRANS_ID_W-1:0] commit_trans_id_i,
  input  logic                  commit_st_barrier_i,
  output logic                  ctrl_halt_o,
  // Accelerator request
  output logic                  acc_req_valid_o,
  output acc_req_t              acc_req_o,
  input  logic                  acc_req_ready_i,
  // Accelerator response
  input  logic                  acc_resp_valid_i,
  input  logic [XLEN-1:0]       acc_resp_result_i,
  input  logic [TRANS_ID_W-1:0] acc_resp_trans_id_i,
  input  logic                  acc_resp_error_i,
  input  logic                  acc_store_pending_i,
  input  logic                  acc_load_complete_i,
  input  logic                  acc_store_complete_i,
  // Result toward the core
  output logic                  acc_valid_o,
  output logic [XLEN-1:0]       acc_result_o,
  output logic [TRANS_ID_W-1:0] acc_trans_id_o,
  output logic                  acc_error_o
);

  // Issue control to queue and trackers
  logic      push;
  logic      issue_ld;
  logic      issue_st;
  // Queue status and head entry
  logic      queue_ready;
  logic      queue_empty;
  acc_insn_t queue_in;
  acc_insn_t queue_head;
  // Dispatch gate
  logic      disp_valid;
  logic      disp_pop;
  logic      disp_ld;
  logic      disp_st;
  // Request register
  logic      req_ready;
  acc_req_t  req_in;
  // Pending memory operations
  logic      no_ld_pending;
  logic      no_st_pending;

  // Execute-stage data is valid in the push cycle
  assign queue_in = '{
    insn:      ex_insn_i,
    operand_a: ex_operand_a_i,
    operand_b: ex_operand_b_i,
    trans_id:  ex_trans_id_i,
    op:        ex_op_i
  };

  // Rounding mode is sampled live, in-order commit keeps it current
  assign req_in = '{
    insn:     queue_head.insn,
    rs1:      queue_head.operand_a,
    rs2:      queue_head.operand_b,
    frm:      fcsr_frm_i,
    trans_id: queue_head.trans_id
  };

  acc_issue_ctrl i_issue_ctrl (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .issue_hs_i       (issue_hs_i),
    .issue_done_i     (issue_done_i),
    .issue_fu_i       (issue_fu_i),
    .issue_op_i       (issue_op_i),
    .flush_unissued_i (flush_unissued_i),
    .queue_ready_i    (queue_ready),
    .no_ld_pending_i  (no_ld_pending),
    .no_st_pending_i  (no_st_pending),
    .acc_cons_en_i    (acc_cons_en_i),
    .push_o           (push),
    .issue_ld_o       (issue_ld),
    .issue_st_o       (issue_st),
    .issue_stall_o    (issue_stall_o)
  );

  acc_insn_queue #(
    .payload_t (acc_insn_t)
  ) i_insn_queue (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_ex_i),
    .push_i   (push),
    .data_i   (queue_in),
    .pop_i    (disp_pop),
    .data_o   (queue_head),
    .empty_o  (queue_empty),
    .ready_o  (queue_ready)
  );

  acc_spec_tracker i_spec_tracker (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .flush_i           (flush_ex_i),
    .push_i            (push),
    .push_trans_id_i   (ex_trans_id_i),
    .head_valid_i      (~queue_empty),
    .head_trans_id_i   (queue_head.trans_id),
    .head_op_i         (queue_head.op),
    .commit_acc_i      (commit_acc_i),
    .commit_trans_id_i (commit_trans_id_i),
    .req_ready_i       (req_ready),
    .disp_valid_o      (disp_valid),
    .pop_o             (disp_pop),
    .disp_ld_o         (disp_ld),
    .disp_st_o         (disp_st)
  );

  acc_req_reg #(
    .payload_t (acc_req_t)
  ) i_req_reg (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (disp_valid),
    .data_i   (req_in),
    .ready_o  (req_ready),
    .valid_o  (acc_req_valid_o),
    .data_o   (acc_req_o),
    .ready_i  (acc_req_ready_i)
  );

  acc_mem_tracker i_mem_tracker (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .flush_i             (flush_ex_i),
    .issue_ld_i          (issue_ld),
    .issue_st_i          (issue_st),
    .disp_ld_i           (disp_ld),
    .disp_st_i           (disp_st),
    .load_complete_i     (acc_load_complete_i),
    .store_complete_i    (acc_store_complete_i),
    .store_pending_i     (acc_store_pending_i),
    .commit_st_barrier_i (commit_st_barrier_i),
    .no_ld_pending_o     (no_ld_pending),
    .no_st_pending_o     (no_st_pending),
    .ctrl_halt_o         (ctrl_halt_o)
  );

  // Responses go back unchanged, error flags an exception
  assign acc_valid_o    = acc_resp_valid_i;
  assign acc_result_o   = acc_resp_result_i;
  assign acc_trans_id_o = acc_resp_trans_id_i;
  assign acc_error_o    = acc_resp_error_i;

endmodule

// ==== verif/tb_clk_gen.sv ====
// ========================================
// Testbench clock and reset generator
// 10 ns clock, reset held for 16 cycles
// ========================================

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 10,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic arst_n_o
);

  // Free-running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== verif/tb_acc_disp.sv ====
// ========================================
// Accelerator dispatcher testbench
// Directed tests for dispatch, flush,
// back-pressure, responses and barriers
// ========================================

`timescale 1ns/1ps

module tb_acc_disp import acc_disp_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 50;

  logic                  clk;
  logic                  arst_n;
  // DUT inputs
  logic                  issue_hs_i;
  logic                  issue_done_i;
  fu_e                   issue_fu_i;
  acc_op_e               issue_op_i;
  logic                  flush_unissued_i;
  logic                  flush_ex_i;
  logic [31:0]           ex_insn_i;
  logic [XLEN-1:0]       ex_operand_a_i;
  logic [XLEN-1:0]       ex_operand_b_i;
  logic [TRANS_ID_W-1:0] ex_trans_id_i;
  acc_op_e               ex_op_i;
  logic [FRM_W-1:0]      fcsr_frm_i;
  logic                  acc_cons_en_i;
  logic                  commit_acc_i;
  logic [TRANS_ID_W-1:0] commit_trans_id_i;
  logic                  commit_st_barrier_i;
  logic                  acc_req_ready_i;
  logic                  acc_resp_valid_i;
  logic [XLEN-1:0]       acc_resp_result_i;
  logic [TRANS_ID_W-1:0] acc_resp_trans_id_i;
  logic                  acc_resp_error_i;
  logic                  acc_store_pending_i;
  logic                  acc_load_complete_i;
  logic                  acc_store_complete_i;
  // DUT outputs
  logic                  issue_stall_o;
  logic                  ctrl_halt_o;
  logic                  acc_req_valid_o;
  acc_req_t              acc_req_o;
  logic                  acc_valid_o;
  logic [XLEN-1:0]       acc_result_o;
  logic [TRANS_ID_W-1:0] acc_trans_id_o;
  logic                  acc_error_o;

  int     error_cnt;
  int     timeout_cnt;
  integer seed;

  tb_clk_gen i_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  acc_disp_top i_dut (
    .clk_i (clk), .arst_n_i (arst_n),
    .issue_hs_i (issue_hs_i), .issue_done_i (issue_done_i),
    .issue_fu_i (issue_fu_i), .issue_op_i (issue_op_i),
    .flush_unissued_i (flush_unissued_i), .flush_ex_i (flush_ex_i),
    .ex_insn_i (ex_insn_i), .ex_operand_a_i (ex_operand_a_i),
    .ex_operand_b_i (ex_operand_b_i), .ex_trans_id_i (ex_trans_id_i),
    .ex_op_i (ex_op_i), .fcsr_frm_i (fcsr_frm_i),
    .acc_cons_en_i (acc_cons_en_i), .issue_stall_o (issue_stall_o),
    .commit_acc_i (commit_acc_i), .commit_trans_id_i (commit_trans_id_i),
    .commit_st_barrier_i (commit_st_barrier_i), .ctrl_halt_o (ctrl_halt_o),
    .acc_req_valid_o (acc_req_valid_o), .acc_req_o (acc_req_o),
    .acc_req_ready_i (acc_req_ready_i),
    .acc_resp_valid_i (acc_resp_valid_i), .acc_resp_result_i (acc_resp_result_i),
    .acc_resp_trans_id_i (acc_resp_trans_id_i), .acc_resp_error_i (acc_resp_error_i),
    .acc_store_pending_i (acc_store_pending_i),
    .acc_load_complete_i (acc_load_complete_i),
    .acc_store_complete_i (acc_store_complete_i),
    .acc_valid_o (acc_valid_o), .acc_result_o (acc_result_o),
    .acc_trans_id_o (acc_trans_id_o), .acc_error_o (acc_error_o)
  );

  // Compare a value of up to 32 bits
  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      error_cnt++;
      $display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timeout_cnt++;
    $display("Timeout at %0t: %s did not happen in time", $time, what);
  endtask

  // Handshake in one cycle and operands in the next
  task automatic issue_insn(input logic [31:0] insn, input logic [XLEN-1:0] op_a,
                            input logic [XLEN-1:0] op_b, input logic [TRANS_ID_W-1:0] id,
                            input acc_op_e op);
    @(negedge clk);
    issue_hs_i     = 1'b1;
    issue_fu_i     = FU_ACCEL;
    issue_op_i     = op;
    @(negedge clk);
    issue_hs_i     = 1'b0;
    issue_fu_i     = FU_NONE;
    ex_insn_i      = insn;
    ex_operand_a_i = op_a;
    ex_operand_b_i = op_b;
    ex_trans_id_i  = id;
    ex_op_i        = op;
  endtask

  task automatic commit_insn(input logic [TRANS_ID_W-1:0] id);
    @(negedge clk);
    commit_acc_i      = 1'b1;
    commit_trans_id_i = id;
    @(negedge clk);
    commit_acc_i      = 1'b0;
  endtask

  // Sample just after the falling edge until the request shows up
  task automatic wait_req_valid(output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < TIMEOUT_CYCLES; n++) begin
      #1;
      if (acc_req_valid_o) begin
        seen = 1'b1;
        break;
      end
      @(negedge clk);
    end
    if (!seen) note_timeout("accelerator request");
  endtask

  // One cycle of ready takes the held request
  task automatic accept_req();
    @(negedge clk);
    acc_req_ready_i = 1'b1;
    @(negedge clk);
    acc_req_ready_i = 1'b0;
  endtask

  task automatic wait_reset_release();
    int n;
    for (n = 0; n < TIMEOUT_CYCLES && arst_n !== 1'b1; n++) begin
      @(negedge clk);
      #1;
    end
    if (arst_n !== 1'b1) note_timeout("reset release");
  endtask

  task automatic dispatch_after_commit();
    logic [31:0] insn;
    logic [31:0] op_a;
    logic [31:0] op_b;
    bit          seen;
    int          n;
    insn = $random(seed);
    op_a = $random(seed);
    op_b = $random(seed);
    @(negedge clk);
    fcsr_frm_i = FRM_W'($random(seed));
    acc_req_ready_i = 1'b0;
    issue_insn(insn, op_a, op_b, 3'd1, ACC_OP_OTHER);
    // Still speculative so nothing may leave
    for (n = 0; n < 2; n++) begin
      @(negedge clk);
      #1;
      check_word("request before commit", 32'(acc_req_valid_o), 32'd0);
    end
    commit_insn(3'd1);
    wait_req_valid(seen);
    if (seen) begin
      check_word("request insn", acc_req_o.insn, insn);
      check_word("request rs1", acc_req_o.rs1, op_a);
      check_word("request rs2", acc_req_o.rs2, op_b);
      check_word("request frm", 32'(acc_req_o.frm), 32'(fcsr_frm_i));
      check_word("request trans_id", 32'(acc_req_o.trans_id), 32'd1);
    end
    accept_req();
    #1;
    check_word("request after accept", 32'(acc_req_valid_o), 32'd0);
  endtask

  task automatic flush_discards();
    int n;
    @(negedge clk);
    acc_req_ready_i = 1'b0;
    issue_insn($random(seed), $random(seed), $random(seed), 3'd2, ACC_OP_STORE);
    issue_insn($random(seed), $random(seed), $random(seed), 3'd3, ACC_OP_STORE);
    @(negedge clk);
    flush_ex_i = 1'b1;
    @(negedge clk);
    flush_ex_i = 1'b0;
    // Commits of flushed IDs are ignored
    commit_insn(3'd2);
    commit_insn(3'd3);
    for (n = 0; n < 20; n++) begin
      @(negedge clk);
      #1;
      check_word("request after flush", 32'(acc_req_valid_o), 32'd0);
    end
    // Flushed stores leave no pending count
    @(negedge clk);
    acc_cons_en_i = 1'b1;
    issue_fu_i    = FU_STORE;
    #1;
    check_word("scalar store stall after flush", 32'(issue_stall_o), 32'd0);
    @(negedge clk);
    acc_cons_en_i = 1'b0;
    issue_fu_i    = FU_NONE;
  endtask

  task automatic backpressure_order();
    logic [31:0]           insn_q[$];
    logic [TRANS_ID_W-1:0] id_q[$];
    logic [31:0]           insn;
    acc_req_t              held;
    bit                    stalled;
    int                    n;
    int                    idx;
    acc_req_ready_i = 1'b0;
    stalled = 1'b0;
    for (n = 0; n < 2 * INSN_QUEUE_DEPTH && !stalled; n++) begin
      @(negedge clk);
      issue_fu_i = FU_ACCEL;
      #1;
      if (issue_stall_o) begin
        stalled = 1'b1;
      end else begin
        insn = $random(seed);
        insn_q.push_back(insn);
        id_q.push_back(TRANS_ID_W'(n));
        issue_insn(insn, $random(seed), $random(seed), TRANS_ID_W'(n), ACC_OP_OTHER);
        commit_insn(TRANS_ID_W'(n));
      end
    end
    if (!stalled) note_timeout("issue stall on a full queue");
    // One request held outside and depth minus one waiting in the queue
    check_word("instructions taken before stall", 32'(insn_q.size()), INSN_QUEUE_DEPTH);
    held = acc_req_o;
    check_word("held request insn", held.insn, insn_q[0]);
    for (n = 0; n < 3; n++) begin
      @(negedge clk);
      #1;
      check_word("held request valid", 32'(acc_req_valid_o), 32'd1);
      check_word("held request stable", 32'(acc_req_o == held), 32'd1);
    end
    @(negedge clk);
    issue_fu_i      = FU_NONE;
    acc_req_ready_i = 1'b1;
    idx = 0;
    for (n = 0; n < TIMEOUT_CYCLES && idx < insn_q.size(); n++) begin
      #1;
      if (acc_req_valid_o) begin
        check_word("drained insn order", acc_req_o.insn, insn_q[idx]);
        check_word("drained trans_id order", 32'(acc_req_o.trans_id), 32'(id_q[idx]));
        idx++;
      end
      @(negedge clk);
    end
    if (idx < insn_q.size()) note_timeout("draining of held requests");
    acc_req_ready_i = 1'b0;
  endtask

  task automatic response_passthrough();
    int n;
    for (n = 0; n < 8; n++) begin
      @(negedge clk);
      acc_resp_valid_i    = 1'($random(seed));
      acc_resp_result_i   = $random(seed);
      acc_resp_trans_id_i = TRANS_ID_W'($random(seed));
      acc_resp_error_i    = 1'($random(seed));
      #1;
      check_word("response valid", 32'(acc_valid_o), 32'(acc_resp_valid_i));
      check_word("response result", acc_result_o, acc_resp_result_i);
      check_word("response trans_id", 32'(acc_trans_id_o), 32'(acc_resp_trans_id_i));
      check_word("response error", 32'(acc_error_o), 32'(acc_resp_error_i));
    end
    @(negedge clk);
    acc_resp_valid_i = 1'b0;
  endtask

  // Issue, commit and hand over one accelerator store
  task automatic dispatch_store(input logic [TRANS_ID_W-1:0] id);
    bit seen;
    issue_insn($random(seed), $random(seed), $random(seed), id, ACC_OP_STORE);
    commit_insn(id);
    wait_req_valid(seen);
    accept_req();
  endtask

  task automatic memory_consistency();
    int n;
    acc_cons_en_i = 1'b1;
    dispatch_store(3'd5);
    @(negedge clk);
    issue_fu_i = FU_LOAD;
    for (n = 0; n < 3; n++) begin
      #1;
      check_word("scalar load stall behind store", 32'(issue_stall_o), 32'd1);
      @(negedge clk);
    end
    acc_store_complete_i = 1'b1;
    #1;
    check_word("stall in completion cycle", 32'(issue_stall_o), 32'd1);
    @(negedge clk);
    acc_store_complete_i = 1'b0;
    #1;
    check_word("stall after completion", 32'(issue_stall_o), 32'd0);
    // Loads never wait with consistency off
    @(negedge clk);
    acc_cons_en_i = 1'b0;
    issue_fu_i    = FU_NONE;
    dispatch_store(3'd6);
    @(negedge clk);
    issue_fu_i = FU_LOAD;
    #1;
    check_word("scalar load stall, consistency off", 32'(issue_stall_o), 32'd0);
    @(negedge clk);
    acc_store_complete_i = 1'b1;
    issue_fu_i           = FU_NONE;
    @(negedge clk);
    acc_store_complete_i = 1'b0;
  endtask

  task automatic store_barrier();
    int n;
    @(negedge clk);
    acc_store_pending_i = 1'b1;
    #1;
    check_word("halt before barrier", 32'(ctrl_halt_o), 32'd0);
    @(negedge clk);
    commit_st_barrier_i = 1'b1;
    @(negedge clk);
    commit_st_barrier_i = 1'b0;
    #1;
    check_word("halt after barrier", 32'(ctrl_halt_o), 32'd1);
    for (n = 0; n < 4; n++) begin
      @(negedge clk);
      #1;
      check_word("halt while store pending", 32'(ctrl_halt_o), 32'd1);
    end
    @(negedge clk);
    acc_store_pending_i = 1'b0;
    #1;
    check_word("halt in release cycle", 32'(ctrl_halt_o), 32'd1);
    @(negedge clk);
    #1;
    check_word("halt after release", 32'(ctrl_halt_o), 32'd0);
  endtask

  initial begin
    error_cnt   = 0;
    timeout_cnt = 0;
    seed        = 75829;
    // Every DUT input idle at time zero
    issue_hs_i           = 1'b0;
    issue_done_i         = 1'b0;
    issue_fu_i           = FU_NONE;
    issue_op_i           = ACC_OP_OTHER;
    flush_unissued_i     = 1'b0;
    flush_ex_i           = 1'b0;
    ex_insn_i            = '0;
    ex_operand_a_i       = '0;
    ex_operand_b_i       = '0;
    ex_trans_id_i        = '0;
    ex_op_i              = ACC_OP_OTHER;
    fcsr_frm_i           = '0;
    acc_cons_en_i        = 1'b0;
    commit_acc_i         = 1'b0;
    commit_trans_id_i    = '0;
    commit_st_barrier_i  = 1'b0;
    acc_req_ready_i      = 1'b0;
    acc_resp_valid_i     = 1'b0;
    acc_resp_result_i    = '0;
    acc_resp_trans_id_i  = '0;
    acc_resp_error_i     = 1'b0;
    acc_store_pending_i  = 1'b0;
    acc_load_complete_i  = 1'b0;
    acc_store_complete_i = 1'b0;

    wait_reset_release();
    check_word("request valid after reset", 32'(acc_req_valid_o), 32'd0);
    check_word("halt after reset", 32'(ctrl_halt_o), 32'd0);
    check_word("stall after reset", 32'(issue_stall_o), 32'd0);

    dispatch_after_commit();
    flush_discards();
    backpressure_order();
    response_passthrough();
    memory_consistency();
    store_barrier();

    $display("Checks failed: %0d, timeouts: %0d", error_cnt, timeout_cnt);
    if (error_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== acc_disp.f ====
common/acc_disp_pkg.sv
hw/acc_dispatcher/acc_pending_counter.sv
hw/acc_dispatcher/acc_mem_tracker.sv
hw/acc_dispatcher/acc_issue_ctrl.sv
hw/acc_dispatcher/acc_insn_queue.sv
hw/acc_dispatcher/acc_spec_tracker.sv
hw/acc_dispatcher/acc_req_reg.sv
hw/acc_dispatcher/acc_disp_top.sv
verif/tb_clk_gen.sv
verif/tb_acc_disp.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the dispatcher testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f acc_disp.f --top-module tb_acc_disp \
  -Mdir "$BUILD_DIR" -o tb_acc_disp
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_acc_disp" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG_FILE"; then
  echo "Result: FAIL"
  exit 1
fi

echo "Result: PASS"
exit 0
